// ==== design/uart_reg_pkg.sv ====
`default_nettype none

package uart_reg_pkg;

   localparam int WIDTH      = 32; // Bus data width
   localparam int ADDR_WIDTH = 4;

   // Register map
   localparam logic [ADDR_WIDTH-1:0] REG_DR         = 4'd0;  // Tx on write, Rx on read
   localparam logic [ADDR_WIDTH-1:0] REG_CTRL       = 4'd1;
   localparam logic [ADDR_WIDTH-1:0] REG_RSTAT      = 4'd2;
   localparam logic [ADDR_WIDTH-1:0] REG_TSTAT      = 4'd3;
   localparam logic [ADDR_WIDTH-1:0] REG_CPB        = 4'd4;
   localparam logic [ADDR_WIDTH-1:0] REG_STORE_BASE = 4'd12; // Four scratch words, 12 to 15

   // Receive status bits
   localparam int STAT_RXNE    = 0; // Byte waiting to be read
   localparam int STAT_BREAK   = 1;
   localparam int STAT_RXVALID = 2;

   // Transmit status bits
   localparam int STAT_TC = 0; // Transmission complete

   // Control bits
   localparam int CTRL_RX_EN = 0;
   localparam int CTRL_TX_EN = 1;

   // 25 MHz / 217 gives about 115200 baud
   localparam logic [WIDTH-1:0] CPB_RESET = 32'd217;

endpackage

`default_nettype wire

// ==== design/uart_line_pkg.sv ====
`default_nettype none

package uart_line_pkg;

   // Frame format, 8N1
   localparam int DATA_BITS  = 8;
   localparam int FRAME_BITS = 10; // Start, data and stop

   localparam logic LINE_IDLE = 1'b1; // Mark level

   // Receiver front end
   localparam int SYNC_STAGES = 2;

   // Below this the half-bit sample point gets too coarse
   localparam int MIN_CPB = 4;

endpackage

`default_nettype wire

// ==== design/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx
(
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 tx_start,
   input  logic [uart_line_pkg::DATA_BITS-1:0]  tx_data,
   input  logic [uart_reg_pkg::WIDTH-1:0]       cycles_per_bit,
   output logic                                 TxD,
   output logic                                 tx_busy
);

   localparam int IDX_W = $clog2(uart_line_pkg::FRAME_BITS);

   logic [uart_reg_pkg::WIDTH-1:0]       cpb_q;   // Bit period frozen for this frame
   logic [uart_reg_pkg::WIDTH-1:0]       cnt;     // Clocks into the current bit
   logic [IDX_W-1:0]                     bit_idx; // 0 start, 1 to 8 data, 9 stop
   logic [uart_line_pkg::DATA_BITS-1:0]  shift;   // Remaining data bits, idle fill on top
   logic                                 bit_end;

   assign bit_end = (cnt == cpb_q - 1'b1);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         tx_busy <= 1'b0;
         TxD     <= uart_line_pkg::LINE_IDLE;
         cnt     <= '0;
         bit_idx <= '0;
      end
      else if (!tx_busy)
      begin
         // A start pulse while busy never reaches this branch
         if (tx_start)
         begin
            tx_busy <= 1'b1;
            TxD     <= ~uart_line_pkg::LINE_IDLE; // Start bit
            cnt     <= '0;
            bit_idx <= '0;
         end
      end
      else if (bit_end)
      begin
         cnt <= '0;
         if (bit_idx == IDX_W'(uart_line_pkg::FRAME_BITS - 1))
         begin
            tx_busy <= 1'b0; // End of stop bit, line already idle
         end
         else
         begin
            bit_idx <= bit_idx + 1'b1;
            TxD     <= shift[0];
         end
      end
      else
      begin
         cnt <= cnt + 1'b1;
      end
   end

   // Frame payload
   always_ff @(posedge clk)
   begin
      if (!tx_busy && tx_start)
      begin
         shift <= tx_data;
         cpb_q <= cycles_per_bit;
      end
      else if (tx_busy && bit_end)
      begin
         shift <= {uart_line_pkg::LINE_IDLE, shift[uart_line_pkg::DATA_BITS-1:1]}; // LSB first
      end
   end

   // Line must rest at mark between frames
   a_idle_when_free: assert property (@(posedge clk) disable iff (reset)
      !tx_busy |-> TxD == uart_line_pkg::LINE_IDLE);

   a_busy_needs_start: assert property (@(posedge clk) disable iff (reset)
      $rose(tx_busy) |-> $past(tx_start));

endmodule

`default_nettype wire

// ==== design/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx
(
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 RxD,
   input  logic                                 rx_en,
   input  logic [uart_reg_pkg::WIDTH-1:0]       cycles_per_bit,
   output logic                                 rx_valid,
   output logic                                 rx_break,
   output logic [uart_line_pkg::DATA_BITS-1:0]  rx_data
);

   localparam int IDX_W = $clog2(uart_line_pkg::DATA_BITS);

   typedef enum logic [2:0]
   {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP,
      RX_BREAK
   } rx_state_t;

   rx_state_t                              state;
   logic [uart_line_pkg::SYNC_STAGES-1:0]  sync;       // Metastability chain
   logic                                   rxd_s;
   logic                                   rxd_prev;
   logic                                   start_edge;
   logic [uart_reg_pkg::WIDTH-1:0]         cpb_q;
   logic [uart_reg_pkg::WIDTH-1:0]         cnt;
   logic [IDX_W-1:0]                       bit_idx;
   logic [uart_line_pkg::DATA_BITS-1:0]    shift;
   logic                                   half_end;
   logic                                   bit_end;
   logic                                   take_start;
   logic                                   take_bit;
   logic                                   take_byte;

   assign rxd_s      = sync[uart_line_pkg::SYNC_STAGES-1];
   assign start_edge = (rxd_prev == uart_line_pkg::LINE_IDLE) &&
                       (rxd_s != uart_line_pkg::LINE_IDLE);
   assign half_end   = (cnt == (cpb_q >> 1) - 1'b1); // Middle of start bit
   assign bit_end    = (cnt == cpb_q - 1'b1);

   assign take_start = rx_en && (state == RX_IDLE) && start_edge;
   assign take_bit   = rx_en && (state == RX_DATA) && bit_end;
   assign take_byte  = rx_en && (state == RX_STOP) && bit_end &&
                       (rxd_s == uart_line_pkg::LINE_IDLE);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         sync     <= {uart_line_pkg::SYNC_STAGES{uart_line_pkg::LINE_IDLE}};
         rxd_prev <= uart_line_pkg::LINE_IDLE;
      end
      else
      begin
         sync     <= {sync[uart_line_pkg::SYNC_STAGES-2:0], RxD};
         rxd_prev <= rxd_s;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= RX_IDLE;
         cnt      <= '0;
         bit_idx  <= '0;
         rx_valid <= 1'b0;
         rx_break <= 1'b0;
      end
      else if (!rx_en)
      begin
         state    <= RX_IDLE;
         rx_break <= 1'b0;
      end
      else
      begin
         case (state)
            RX_IDLE:
               if (start_edge)
               begin
                  state    <= RX_START;
                  cnt      <= '0;
                  rx_valid <= 1'b0; // Previous byte no longer current
               end
            RX_START:
               if (half_end)
               begin
                  cnt     <= '0;
                  bit_idx <= '0;
                  // High at mid-bit means a glitch
                  state   <= (rxd_s == uart_line_pkg::LINE_IDLE) ? RX_IDLE : RX_DATA;
               end
               else
                  cnt <= cnt + 1'b1;
            RX_DATA:
               if (bit_end)
               begin
                  cnt     <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == IDX_W'(uart_line_pkg::DATA_BITS - 1))
                     state <= RX_STOP;
               end
               else
                  cnt <= cnt + 1'b1;
            RX_STOP:
               if (bit_end)
               begin
                  cnt <= '0;
                  if (rxd_s == uart_line_pkg::LINE_IDLE)
                  begin
                     rx_valid <= 1'b1;
                     state    <= RX_IDLE;
                  end
                  else if (shift == '0)
                  begin
                     rx_break <= 1'b1; // Low through the whole frame
                     state    <= RX_BREAK;
                  end
                  else
                     state <= RX_IDLE; // Framing error, byte dropped
               end
               else
                  cnt <= cnt + 1'b1;
            RX_BREAK:
               if (rxd_s == uart_line_pkg::LINE_IDLE)
               begin
                  rx_break <= 1'b0;
                  state    <= RX_IDLE;
               end
            default:
               state <= RX_IDLE;
         endcase
      end
   end

   // Sample shift register and output byte
   always_ff @(posedge clk)
   begin
      if (take_start)
         cpb_q <= cycles_per_bit;
      if (take_bit)
         shift <= {rxd_s, shift[uart_line_pkg::DATA_BITS-1:1]};
      if (take_byte)
         rx_data <= shift;
   end

   a_valid_break_excl: assert property (@(posedge clk) disable iff (reset)
      !(rx_valid && rx_break));

endmodule

`default_nettype wire

// ==== design/uart.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart
(
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 cs,
   input  logic                                 wen,
   input  logic [uart_reg_pkg::ADDR_WIDTH-1:0]  addr,
   input  logic [uart_reg_pkg::WIDTH-1:0]       din,
   output logic [uart_reg_pkg::WIDTH-1:0]       dout,
   input  logic                                 RxD,
   output logic                                 TxD
);

   typedef enum logic [1:0]
   {
      FSM_IDLE    = 2'b00,
      FSM_GOT     = 2'b01,
      FSM_READOUT = 2'b10
   } rx_fsm_t;

   logic                                 wr;
   logic                                 store_sel;
   logic [uart_reg_pkg::WIDTH-1:0]       control;
   logic [uart_reg_pkg::WIDTH-1:0]       cycles_per_bit;
   logic [uart_reg_pkg::WIDTH-1:0]       store [4];
   logic                                 tx_start;
   logic                                 tx_busy;
   logic                                 rx_en;
   logic                                 rx_valid;
   logic                                 rx_break;
   logic [uart_line_pkg::DATA_BITS-1:0]  rx_data;
   rx_fsm_t                              rx_fsm;
   logic                                 rx_readout;
   logic                                 rx_not_empty;
   logic [uart_reg_pkg::WIDTH-1:0]       rstat;
   logic [uart_reg_pkg::WIDTH-1:0]       tstat;

   assign wr = cs & wen;

   // Top two address bits pick the scratch bank
   assign store_sel = (addr[uart_reg_pkg::ADDR_WIDTH-1:2] ==
                       uart_reg_pkg::REG_STORE_BASE[uart_reg_pkg::ADDR_WIDTH-1:2]);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         control        <= '0;
         cycles_per_bit <= uart_reg_pkg::CPB_RESET;
         for (int i = 0; i < 4; i++)
            store[i] <= '0;
      end
      else if (wr)
      begin
         if (addr == uart_reg_pkg::REG_CTRL)
            control <= din;
         if (addr == uart_reg_pkg::REG_CPB)
            cycles_per_bit <= din;
         if (store_sel)
            store[addr[1:0]] <= din;
      end
   end

   // Data register write starts a frame when Tx is enabled
   assign tx_start = wr && (addr == uart_reg_pkg::REG_DR) &&
                     control[uart_reg_pkg::CTRL_TX_EN];
   assign rx_en    = control[uart_reg_pkg::CTRL_RX_EN];

   uart_tx utx
   (
      .clk            (clk),
      .reset          (reset),
      .tx_start       (tx_start),
      .tx_data        (din[uart_line_pkg::DATA_BITS-1:0]),
      .cycles_per_bit (cycles_per_bit),
      .TxD            (TxD),
      .tx_busy        (tx_busy)
   );

   uart_rx urx
   (
      .clk            (clk),
      .reset          (reset),
      .RxD            (RxD),
      .rx_en          (rx_en),
      .cycles_per_bit (cycles_per_bit),
      .rx_valid       (rx_valid),
      .rx_break       (rx_break),
      .rx_data        (rx_data)
   );

   // Tracks whether the current received byte has been read
   assign rx_readout = cs && !wen && (addr == uart_reg_pkg::REG_DR);

   always_ff @(posedge clk)
   begin
      if (reset)
         rx_fsm <= FSM_IDLE;
      else
      begin
         case (rx_fsm)
            FSM_IDLE:    rx_fsm <= rx_valid ? FSM_GOT : FSM_IDLE;
            FSM_GOT:     rx_fsm <= rx_readout ? FSM_READOUT : FSM_GOT;
            FSM_READOUT: rx_fsm <= !rx_valid ? FSM_IDLE : FSM_READOUT; // Wait for next start
            default:     rx_fsm <= FSM_IDLE;
         endcase
      end
   end

   assign rx_not_empty = (rx_fsm == FSM_GOT);

   always_comb
   begin
      rstat = '0;
      rstat[uart_reg_pkg::STAT_RXNE]    = rx_not_empty;
      rstat[uart_reg_pkg::STAT_BREAK]   = rx_break;
      rstat[uart_reg_pkg::STAT_RXVALID] = rx_valid;
      tstat = '0;
      tstat[uart_reg_pkg::STAT_TC] = !tx_busy;
   end

   // Read mux
   always_comb
   begin
      if (store_sel)
         dout = store[addr[1:0]];
      else
      begin
         case (addr)
            uart_reg_pkg::REG_DR:
               dout = {{(uart_reg_pkg::WIDTH - uart_line_pkg::DATA_BITS){1'b0}}, rx_data};
            uart_reg_pkg::REG_CTRL:  dout = control;
            uart_reg_pkg::REG_RSTAT: dout = rstat;
            uart_reg_pkg::REG_TSTAT: dout = tstat;
            uart_reg_pkg::REG_CPB:   dout = cycles_per_bit;
            default:                 dout = '0; // Holes at 5 to 11
         endcase
      end
   end

   a_fsm_legal: assert property (@(posedge clk) disable iff (reset)
      rx_fsm inside {FSM_IDLE, FSM_GOT, FSM_READOUT});

   // Both engines rely on a usable half-bit point
   a_cpb_min: assert property (@(posedge clk) disable iff (reset)
      (wr && (addr == uart_reg_pkg::REG_CPB)) |-> din >= uart_line_pkg::MIN_CPB);

endmodule

`default_nettype wire

// ==== tb/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen
(
   output logic clk,
   output logic reset
);

   localparam int HALF_PERIOD  = 50; // 100 ns clock
   localparam int RESET_CYCLES = 10;

   initial
   begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   initial
   begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

`default_nettype wire

// ==== tb/uart_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

   localparam int POLL_LIMIT  = 400; // Status reads before giving up
   localparam int RESET_LIMIT = 100;

   logic                                 clk;
   logic                                 reset;
   logic                                 cs;
   logic                                 wen;
   logic [uart_reg_pkg::ADDR_WIDTH-1:0]  addr;
   logic [uart_reg_pkg::WIDTH-1:0]       din;
   logic [uart_reg_pkg::WIDTH-1:0]       dout;
   logic                                 RxD;
   logic                                 TxD;

   // Register model
   logic [31:0] ctrl_m;
   logic [31:0] cpb_m;
   logic [31:0] store_m [4];

   int          errors;
   int          timeouts;

   clock_gen clock_gen_i (.clk(clk), .reset(reset));

   uart UUT
   (
      .clk   (clk),
      .reset (reset),
      .cs    (cs),
      .wen   (wen),
      .addr  (addr),
      .din   (din),
      .dout  (dout),
      .RxD   (RxD),
      .TxD   (TxD)
   );

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
      if (got !== exp)
      begin
         errors++;
         $display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, exp);
      end
   endtask

   function automatic logic [31:0] model_value(input logic [3:0] a);
      if (a == uart_reg_pkg::REG_CTRL)
         return ctrl_m;
      if (a == uart_reg_pkg::REG_CPB)
         return cpb_m;
      if (a >= uart_reg_pkg::REG_STORE_BASE)
         return store_m[2'(a - uart_reg_pkg::REG_STORE_BASE)];
      return 32'd0; // Unmapped
   endfunction

   task automatic bus_write(input logic [3:0] a, input logic [31:0] d);
      @(posedge clk);
      cs   <= 1'b1;
      wen  <= 1'b1;
      addr <= a;
      din  <= d;
      @(posedge clk); // Write lands here
      cs   <= 1'b0;
      wen  <= 1'b0;
   endtask

   task automatic bus_read(input logic [3:0] a, output logic [31:0] d);
      @(posedge clk);
      cs   <= 1'b1;
      wen  <= 1'b0;
      addr <= a;
      @(negedge clk);
      d = dout;
      @(posedge clk);
      cs   <= 1'b0;
   endtask

   task automatic set_ctrl(input logic [31:0] v);
      bus_write(uart_reg_pkg::REG_CTRL, v);
      ctrl_m = v;
   endtask

   task automatic set_cpb(input logic [31:0] v);
      bus_write(uart_reg_pkg::REG_CPB, v);
      cpb_m = v;
   endtask

   // Serial line model, one frame on RxD
   task automatic send_frame(input logic [7:0] data);
      logic [9:0] bits;
      bits = {1'b1, data, 1'b0};
      for (int i = 0; i < uart_line_pkg::FRAME_BITS; i++)
      begin
         @(posedge clk);
         RxD <= bits[4'(i)];
         repeat (cpb_m - 1) @(posedge clk);
      end
   endtask

   task automatic wait_status(input int bit_pos, input logic level, input string what);
      logic [31:0] v;
      int          tries;
      tries = 0;
      bus_read(uart_reg_pkg::REG_RSTAT, v);
      while (v[5'(bit_pos)] !== level && tries < POLL_LIMIT)
      begin
         bus_read(uart_reg_pkg::REG_RSTAT, v);
         tries++;
      end
      if (v[5'(bit_pos)] !== level)
      begin
         timeouts++;
         $display("ERROR at %0t: timed out waiting for %s", $time, what);
      end
   endtask

   task automatic check_tx_idle(input int cycles, input string what);
      logic low_seen;
      low_seen = 1'b0;
      repeat (cycles)
      begin
         @(negedge clk);
         if (TxD !== uart_line_pkg::LINE_IDLE)
            low_seen = 1'b1;
      end
      check(32'(low_seen), 32'd0, what);
   endtask

   // Writes one byte, decodes TxD at mid-bit and watches TSTAT every cycle
   task automatic tx_frame(input logic [7:0] data, input logic inject, input logic [7:0] extra);
      logic [9:0]  seen;
      logic [31:0] noise;
      int          bl;
      int          frame_len;
      bl        = cpb_m;
      frame_len = uart_line_pkg::FRAME_BITS * bl;
      seen      = '0;
      noise     = $urandom;
      @(posedge clk);
      cs   <= 1'b1;
      wen  <= 1'b1;
      addr <= uart_reg_pkg::REG_DR;
      din  <= {noise[31:8], data}; // Upper bits are ignored
      @(posedge clk);
      wen  <= 1'b0;
      addr <= uart_reg_pkg::REG_TSTAT;
      for (int cyc = 0; cyc <= frame_len; cyc++)
      begin
         @(negedge clk);
         if (addr == uart_reg_pkg::REG_TSTAT)
            check(dout, (cyc == frame_len) ? 32'd1 : 32'd0, $sformatf("TSTAT cycle %0d", cyc));
         if (cyc % bl == bl / 2)
            seen[4'(cyc / bl)] = TxD;
         if (inject && cyc == 3 * bl)
         begin
            @(posedge clk); // Second write lands mid-frame
            wen  <= 1'b1;
            addr <= uart_reg_pkg::REG_DR;
            din  <= {24'h0, extra};
         end
         else if (wen)
         begin
            @(posedge clk);
            wen  <= 1'b0;
            addr <= uart_reg_pkg::REG_TSTAT;
         end
      end
      check(32'(TxD), 32'd1, "TxD after stop bit");
      @(posedge clk);
      cs <= 1'b0;
      check(32'(seen), {22'h0, 1'b1, data, 1'b0}, "TxD frame bits");
   endtask

   task automatic register_test();
      logic [31:0] v;
      logic [31:0] w;
      logic [3:0]  a;
      int          pick;
      bus_read(uart_reg_pkg::REG_CTRL, v);
      check(v, 32'd0, "CTRL after reset");
      bus_read(uart_reg_pkg::REG_CPB, v);
      check(v, 32'd217, "CPB after reset");
      for (int k = 0; k < 4; k++)
      begin
         bus_read(uart_reg_pkg::REG_STORE_BASE + 4'(k), v);
         check(v, 32'd0, "storage after reset");
      end
      bus_read(uart_reg_pkg::REG_TSTAT, v);
      check(v, 32'd1 << uart_reg_pkg::STAT_TC, "TSTAT after reset");
      bus_read(uart_reg_pkg::REG_RSTAT, v);
      check(v, 32'd0, "RSTAT after reset");
      for (int n = 0; n < 24; n++)
      begin
         pick = $urandom_range(5, 0);
         w    = $urandom;
         if (pick == 0)
            a = uart_reg_pkg::REG_CTRL;
         else if (pick == 1)
         begin
            a = uart_reg_pkg::REG_CPB;
            if (w < 32'(uart_line_pkg::MIN_CPB))
               w = 32'(uart_line_pkg::MIN_CPB);
         end
         else
            a = uart_reg_pkg::REG_STORE_BASE + 4'(pick - 2);
         bus_write(a, w);
         if (pick == 0)
            ctrl_m = w;
         else if (pick == 1)
            cpb_m = w;
         else
            store_m[2'(pick - 2)] = w;
         bus_read(a, v);
         check(v, model_value(a), $sformatf("readback addr %0d", a));
      end
      // Full sweep, holes included
      for (int k = 1; k < 16; k++)
      begin
         if (k != 2 && k != 3)
         begin
            bus_read(4'(k), v);
            check(v, model_value(4'(k)), $sformatf("sweep addr %0d", k));
         end
      end
   endtask

   task automatic transmit_test();
      logic [31:0] v;
      set_ctrl(32'd1 << uart_reg_pkg::CTRL_TX_EN);
      for (int n = 0; n < 6; n++)
      begin
         set_cpb($urandom_range(20, 8));
         tx_frame(8'($urandom), 1'b0, 8'h00);
      end
      // Write while busy is dropped
      tx_frame(8'($urandom), 1'b1, 8'($urandom));
      check_tx_idle(uart_line_pkg::FRAME_BITS * cpb_m, "TxD idle after dropped write");
      set_ctrl(32'd0);
      bus_write(uart_reg_pkg::REG_DR, 32'h0000_0055);
      check_tx_idle(uart_line_pkg::FRAME_BITS * cpb_m, "TxD idle with Tx disabled");
      bus_read(uart_reg_pkg::REG_TSTAT, v);
      check(v, 32'd1, "TSTAT with Tx disabled");
   endtask

   task automatic receive_test();
      logic [31:0] v;
      logic [7:0]  data;
      // Receiver off first, while rx_valid is still at its reset value
      set_ctrl(32'd0);
      set_cpb($urandom_range(20, 8));
      send_frame(8'($urandom));
      repeat (2 * cpb_m) @(posedge clk);
      bus_read(uart_reg_pkg::REG_RSTAT, v);
      check(v, 32'd0, "RSTAT with Rx disabled");
      set_ctrl(32'd1 << uart_reg_pkg::CTRL_RX_EN);
      for (int n = 0; n < 6; n++)
      begin
         set_cpb($urandom_range(20, 8));
         data = 8'($urandom);
         send_frame(data);
         wait_status(uart_reg_pkg::STAT_RXNE, 1'b1, "received byte");
         bus_read(uart_reg_pkg::REG_RSTAT, v);
         check(v, (32'd1 << uart_reg_pkg::STAT_RXNE) | (32'd1 << uart_reg_pkg::STAT_RXVALID),
               "RSTAT with byte waiting");
         bus_read(uart_reg_pkg::REG_DR, v);
         check(v, {24'h0, data}, "received data");
         bus_read(uart_reg_pkg::REG_RSTAT, v);
         check(v, 32'd1 << uart_reg_pkg::STAT_RXVALID, "RSTAT after readout");
      end
   endtask

   task automatic break_test();
      logic [31:0] v;
      logic [7:0]  data;
      @(posedge clk);
      RxD <= 1'b0;
      repeat (12 * cpb_m - 1) @(posedge clk); // Twelve bit periods low
      wait_status(uart_reg_pkg::STAT_BREAK, 1'b1, "break flag");
      bus_read(uart_reg_pkg::REG_RSTAT, v);
      check(v, 32'd1 << uart_reg_pkg::STAT_BREAK, "RSTAT during break");
      @(posedge clk);
      RxD <= 1'b1;
      wait_status(uart_reg_pkg::STAT_BREAK, 1'b0, "break flag to clear");
      bus_read(uart_reg_pkg::REG_RSTAT, v);
      check(v, 32'd0, "RSTAT after break");
      data = 8'($urandom);
      send_frame(data);
      wait_status(uart_reg_pkg::STAT_RXNE, 1'b1, "byte after break");
      bus_read(uart_reg_pkg::REG_DR, v);
      check(v, {24'h0, data}, "data after break");
   endtask

   initial
   begin
      int tries;
      cs       = 1'b0;
      wen      = 1'b0;
      addr     = '0;
      din      = '0;
      RxD      = uart_line_pkg::LINE_IDLE;
      errors   = 0;
      timeouts = 0;
      ctrl_m   = '0;
      cpb_m    = uart_reg_pkg::CPB_RESET;
      for (int k = 0; k < 4; k++)
         store_m[k] = '0;
      void'($urandom(32'h3b6e_a838));
      tries    = 0;
      while (reset !== 1'b0 && tries < RESET_LIMIT)
      begin
         @(posedge clk);
         tries++;
      end
      if (reset !== 1'b0)
      begin
         timeouts++;
         $display("ERROR: reset was never released");
      end
      else
      begin
         register_test();
         set_ctrl(32'd0);
         transmit_test();
         receive_test();
         break_test();
      end
      $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
design/uart_reg_pkg.sv
design/uart_line_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart.sv
tb/clock_gen.sv
tb/uart_tb.sv

// ==== Makefile ====
# Verilator build and run for the UART testbench

VERILATOR  ?= verilator
FILELIST   ?= project.f
TOP        ?= uart_tb
RTL_TOP    ?= uart
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) design/uart_reg_pkg.sv design/uart_line_pkg.sv \
		design/uart_tx.sv design/uart_rx.sv design/uart.sv --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
